// ==== rtl/pcie_csr_pkg.sv ====
package pcie_csr_pkg;

   //----------------------------------------------------------------------
   // Address and data widths
   //----------------------------------------------------------------------

   // 4 KB register window, byte addressed
   localparam int MMIO_ADDR_WIDTH = 12;

   typedef logic [MMIO_ADDR_WIDTH-1:0] t_mmio_addr;
   typedef logic [63:0]                t_csr_data;

   // Register index is byte address bits 5:3
   typedef logic [2:0]                 t_reg_idx;

   // Sideband subsystem control fields
   typedef logic [17:0]                t_ss_addr;
   typedef logic [31:0]                t_ss_data;
   typedef logic [1:0]                 t_ss_cmd;

   // 32 error code bits plus completion timeout on top
   localparam int ERR_SRC_WIDTH = 33;

   // Width and lane of a decoded access
   typedef enum logic [1:0] {
      ACC_FULL64,
      ACC_LOWER32,
      ACC_UPPER32
   } e_access_type;

   //----------------------------------------------------------------------
   // Register map
   //----------------------------------------------------------------------

   // One 8-byte register per index
   localparam t_reg_idx REG_DFH      = 3'd0;
   localparam t_reg_idx REG_SCRATCH  = 3'd1;
   localparam t_reg_idx REG_STAT     = 3'd2;
   localparam t_reg_idx REG_ERR_MASK = 3'd3;
   localparam t_reg_idx REG_ERROR    = 3'd4;
   localparam t_reg_idx REG_SS_CMD   = 3'd5;
   localparam t_reg_idx REG_SS_DATA  = 3'd6;
   localparam int       CSR_NUM_REG  = 7;

   // First byte address past the last implemented register
   localparam t_mmio_addr CSR_ADDR_LIMIT = t_mmio_addr'(CSR_NUM_REG * 8);

   //----------------------------------------------------------------------
   // Device feature header
   //----------------------------------------------------------------------
   localparam logic [3:0]  FEAT_TYPE       = 4'h3;
   localparam logic [11:0] FEAT_ID         = 12'h020;
   localparam logic [3:0]  FEAT_VER        = 4'h1;
   localparam logic [23:0] NEXT_DFH_OFFSET = 24'h001000;
   localparam logic        END_OF_LIST     = 1'b0;

   // Type, reserved, EOL, next offset, version, ID from msb down
   localparam t_csr_data DFH_VALUE = {
      FEAT_TYPE, 8'h00, 4'h0, 7'h00, END_OF_LIST,
      NEXT_DFH_OFFSET, FEAT_VER, FEAT_ID
   };

endpackage

// ==== rtl/mmio_req_decode.sv ====
`timescale 1ns/100ps

module mmio_req_decode (
   input  logic                       clk,
   input  logic                       rst_n,

   // Raw MMIO strobes
   input  logic                       i_mmio_write,
   input  logic                       i_mmio_read,
   input  pcie_csr_pkg::t_mmio_addr   i_mmio_addr,
   input  pcie_csr_pkg::t_csr_data    i_mmio_wdata,
   input  logic                       i_mmio_32b,

   // Decoded write
   output logic                       o_csr_write,
   output pcie_csr_pkg::t_mmio_addr   o_csr_waddr,
   output pcie_csr_pkg::t_csr_data    o_csr_wdata,
   output pcie_csr_pkg::e_access_type o_csr_write_type,

   // Decoded read
   output logic                       o_csr_read,
   output pcie_csr_pkg::t_mmio_addr   o_csr_raddr,
   output logic                       o_csr_read_32b
);

   import pcie_csr_pkg::*;

   //----------------------------------------------------------------------
   // Request decode
   //----------------------------------------------------------------------
   logic         write_d;
   logic         read_d;
   e_access_type acc_type_d;

   always_comb begin
      // Write takes the cycle on a collision
      write_d = i_mmio_write;
      read_d  = i_mmio_read & ~i_mmio_write;

      // Address bit 2 picks the lane of a 32-bit access
      if (!i_mmio_32b) begin
         acc_type_d = ACC_FULL64;
      end else if (i_mmio_addr[2]) begin
         acc_type_d = ACC_UPPER32;
      end else begin
         acc_type_d = ACC_LOWER32;
      end
   end

   //----------------------------------------------------------------------
   // Request registers
   //----------------------------------------------------------------------

   // Strobes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_csr_write <= 1'b0;
         o_csr_read  <= 1'b0;
      end else begin
         o_csr_write <= write_d;
         o_csr_read  <= read_d;
      end
   end

   // Write payload, held between writes
   always_ff @(posedge clk) begin
      if (write_d) begin
         o_csr_waddr      <= i_mmio_addr;
         o_csr_wdata      <= i_mmio_wdata;
         o_csr_write_type <= acc_type_d;
      end
   end

   // Read payload, held between reads
   always_ff @(posedge clk) begin
      if (read_d) begin
         o_csr_raddr    <= i_mmio_addr;
         o_csr_read_32b <= i_mmio_32b;
      end
   end

endmodule

// ==== rtl/pcie_err_collect.sv ====
`timescale 1ns/100ps

module pcie_err_collect (
   input  logic                                    clk,
   input  logic                                    rst_n,

   // Async link-up level
   input  logic                                    i_pcie_linkup,

   // Level error sources
   input  logic [31:0]                             i_err_code,
   input  logic                                    i_cpl_timeout,

   output logic                                    o_linkup_sync,
   output logic [pcie_csr_pkg::ERR_SRC_WIDTH-1:0]  o_err_set
);

   import pcie_csr_pkg::*;

   //----------------------------------------------------------------------
   // Link-up synchronizer
   //----------------------------------------------------------------------
   logic linkup_meta;
   logic linkup_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         linkup_meta <= 1'b0;
         linkup_q    <= 1'b0;
      end else begin
         linkup_meta <= i_pcie_linkup;
         linkup_q    <= linkup_meta;
      end
   end

   assign o_linkup_sync = linkup_q;

   //----------------------------------------------------------------------
   // Rising edge detect on error sources
   //----------------------------------------------------------------------
   logic [ERR_SRC_WIDTH-1:0] src_q;
   logic [ERR_SRC_WIDTH-1:0] src_prev_q;

   // History clears in reset
   // A source high out of reset therefore fires once
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         src_q      <= '0;
         src_prev_q <= '0;
         o_err_set  <= '0;
      end else begin
         // Completion timeout sits at bit 32
         src_q      <= {i_cpl_timeout, i_err_code};
         src_prev_q <= src_q;
         o_err_set  <= src_q & ~src_prev_q;
      end
   end

endmodule

// ==== rtl/pcie_csr_regs.sv ====
`timescale 1ns/100ps

module pcie_csr_regs (
   input  logic                                    clk,
   input  logic                                    rst_n,

   // Decoded write
   input  logic                                    i_csr_write,
   input  pcie_csr_pkg::t_mmio_addr                i_csr_waddr,
   input  pcie_csr_pkg::t_csr_data                 i_csr_wdata,
   input  pcie_csr_pkg::e_access_type              i_csr_write_type,

   // Decoded read
   input  logic                                    i_csr_read,
   input  pcie_csr_pkg::t_mmio_addr                i_csr_raddr,
   input  logic                                    i_csr_read_32b,

   // Status and error events
   input  logic                                    i_linkup,
   input  logic [pcie_csr_pkg::ERR_SRC_WIDTH-1:0]  i_err_set,

   // Sideband subsystem returns
   input  logic                                    i_ss_ack,
   input  pcie_csr_pkg::t_ss_data                  i_ss_readdata,

   // Read response
   output logic                                    o_rsp_valid,
   output pcie_csr_pkg::t_csr_data                 o_rsp_data,

   // Sideband subsystem controls
   output pcie_csr_pkg::t_ss_cmd                   o_ss_cmd,
   output pcie_csr_pkg::t_ss_addr                  o_ss_addr,
   output pcie_csr_pkg::t_ss_data                  o_ss_wdata,

   output logic [31:0]                             o_pcie_error
);

   import pcie_csr_pkg::*;

   // Keep old bits outside the mask
   function automatic t_csr_data f_merge(
      input t_csr_data old_val,
      input t_csr_data new_val,
      input t_csr_data mask
   );
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   //----------------------------------------------------------------------
   // Field storage
   //----------------------------------------------------------------------
   t_csr_data                scratch_q;
   logic [ERR_SRC_WIDTH-1:0] err_mask_q;
   logic [ERR_SRC_WIDTH-1:0] error_q;
   t_ss_cmd                  ss_cmd_q;
   t_ss_addr                 ss_addr_q;
   t_ss_data                 ss_wdata_q;

   // Software view of every register
   t_csr_data reg_view [CSR_NUM_REG];

   always_comb begin
      reg_view[REG_DFH]      = DFH_VALUE;
      reg_view[REG_SCRATCH]  = scratch_q;
      // Only link-up in bit 0
      reg_view[REG_STAT]     = {63'h0, i_linkup};
      reg_view[REG_ERR_MASK] = {31'h0, err_mask_q};
      reg_view[REG_ERROR]    = {31'h0, error_q};
      // Ack is read-only at bit 2
      reg_view[REG_SS_CMD]   = {14'h0, ss_addr_q, 29'h0, i_ss_ack, ss_cmd_q};
      // Write data up top, read data from the subsystem below
      reg_view[REG_SS_DATA]  = {ss_wdata_q, i_ss_readdata};
   end

   //----------------------------------------------------------------------
   // Write stage
   //----------------------------------------------------------------------
   logic         wr_q;
   t_mmio_addr   wr_addr_q;
   t_csr_data    wr_data_q;
   e_access_type wr_type_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q <= 1'b0;
      end else begin
         wr_q <= i_csr_write;
      end
   end

   always_ff @(posedge clk) begin
      wr_addr_q <= i_csr_waddr;
      wr_data_q <= i_csr_wdata;
      wr_type_q <= i_csr_write_type;
   end

   // Lane mask and per-register select
   t_csr_data                wr_mask;
   t_reg_idx                 wr_idx;
   logic [CSR_NUM_REG-1:0]   wr_sel;
   logic [ERR_SRC_WIDTH-1:0] err_clr;
   t_csr_data                scratch_nxt;
   t_csr_data                mask_nxt;
   t_csr_data                ss_cmd_nxt;
   t_csr_data                ss_data_nxt;

   always_comb begin
      case (wr_type_q)
         ACC_LOWER32: wr_mask = {32'h0, {32{1'b1}}};
         ACC_UPPER32: wr_mask = {{32{1'b1}}, 32'h0};
         default:     wr_mask = '1;
      endcase

      wr_idx = wr_addr_q[5:3];

      // Nothing selected past the last register
      wr_sel = '0;
      if (wr_q && (wr_addr_q < CSR_ADDR_LIMIT)) begin
         wr_sel[wr_idx] = 1'b1;
      end

      // Write 1 to clear, only inside the written lane
      err_clr = '0;
      if (wr_sel[REG_ERROR]) begin
         err_clr = wr_data_q[ERR_SRC_WIDTH-1:0] & wr_mask[ERR_SRC_WIDTH-1:0];
      end

      scratch_nxt = f_merge(reg_view[REG_SCRATCH], wr_data_q, wr_mask);
      mask_nxt    = f_merge(reg_view[REG_ERR_MASK], wr_data_q, wr_mask);
      ss_cmd_nxt  = f_merge(reg_view[REG_SS_CMD], wr_data_q, wr_mask);
      ss_data_nxt = f_merge(reg_view[REG_SS_DATA], wr_data_q, wr_mask);
   end

   //----------------------------------------------------------------------
   // Register update
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         scratch_q  <= '0;
         err_mask_q <= '0;
         error_q    <= '0;
         ss_cmd_q   <= '0;
         ss_addr_q  <= '0;
         ss_wdata_q <= '0;
      end else begin
         if (wr_sel[REG_SCRATCH]) begin
            scratch_q <= scratch_nxt;
         end
         if (wr_sel[REG_ERR_MASK]) begin
            err_mask_q <= mask_nxt[ERR_SRC_WIDTH-1:0];
         end
         if (wr_sel[REG_SS_CMD]) begin
            ss_cmd_q  <= ss_cmd_nxt[1:0];
            ss_addr_q <= ss_cmd_nxt[49:32];
         end
         if (wr_sel[REG_SS_DATA]) begin
            ss_wdata_q <= ss_data_nxt[63:32];
         end
         // Sticky set of unmasked events; clear wins
         error_q <= (error_q | (i_err_set & ~err_mask_q)) & ~err_clr;
      end
   end

   assign o_ss_cmd     = ss_cmd_q;
   assign o_ss_addr    = ss_addr_q;
   assign o_ss_wdata   = ss_wdata_q;
   assign o_pcie_error = error_q[31:0];

   //----------------------------------------------------------------------
   // Read path
   //----------------------------------------------------------------------

   // Stage 1 holds the request while the range is checked
   logic       rd_q;
   t_mmio_addr rd_addr_q;
   logic       rd_32b_q;
   logic       rd_in_range_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_q <= 1'b0;
      end else begin
         rd_q <= i_csr_read;
      end
   end

   always_ff @(posedge clk) begin
      rd_addr_q     <= i_csr_raddr;
      rd_32b_q      <= i_csr_read_32b;
      rd_in_range_q <= (i_csr_raddr < CSR_ADDR_LIMIT);
   end

   // Lane select on the addressed word
   t_reg_idx  rd_idx;
   t_csr_data rd_word;
   t_csr_data rd_lane;

   always_comb begin
      rd_idx  = rd_addr_q[5:3];
      rd_word = '0;
      if (rd_in_range_q) begin
         rd_word = reg_view[rd_idx];
      end

      // 32-bit read keeps its lane in place
      if (!rd_32b_q) begin
         rd_lane = rd_word;
      end else if (rd_addr_q[2]) begin
         rd_lane = {rd_word[63:32], 32'h0};
      end else begin
         rd_lane = {32'h0, rd_word[31:0]};
      end
   end

   // Stage 2 is the response
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_rsp_valid <= 1'b0;
      end else begin
         o_rsp_valid <= rd_q;
      end
   end

   always_ff @(posedge clk) begin
      o_rsp_data <= rd_q ? rd_lane : '0;
   end

endmodule

// ==== rtl/pcie_csr_top.sv ====
`timescale 1ns/100ps

module pcie_csr_top (
   input  logic                      clk,
   input  logic                      rst_n,

   // MMIO request port
   input  logic                      i_mmio_write,
   input  logic                      i_mmio_read,
   input  pcie_csr_pkg::t_mmio_addr  i_mmio_addr,
   input  pcie_csr_pkg::t_csr_data   i_mmio_wdata,
   input  logic                      i_mmio_32b,

   // Link and error sources
   input  logic                      i_pcie_linkup,
   input  logic [31:0]               i_err_code,
   input  logic                      i_cpl_timeout,

   // Sideband subsystem returns
   input  logic                      i_ss_ack,
   input  pcie_csr_pkg::t_ss_data    i_ss_readdata,

   // Read response
   output logic                      o_rsp_valid,
   output pcie_csr_pkg::t_csr_data   o_rsp_data,

   // Sideband subsystem controls
   output pcie_csr_pkg::t_ss_cmd     o_ss_cmd,
   output pcie_csr_pkg::t_ss_addr    o_ss_addr,
   output pcie_csr_pkg::t_ss_data    o_ss_wdata,

   output logic [31:0]               o_pcie_error
);

   import pcie_csr_pkg::*;

   //----------------------------------------------------------------------
   // Stage interconnect
   //----------------------------------------------------------------------
   logic                     csr_write;
   t_mmio_addr               csr_waddr;
   t_csr_data                csr_wdata;
   e_access_type             csr_write_type;
   logic                     csr_read;
   t_mmio_addr               csr_raddr;
   logic                     csr_read_32b;

   logic                     linkup_sync;
   logic [ERR_SRC_WIDTH-1:0] err_set;

   // Request stage
   mmio_req_decode u_req (
      .clk              (clk),
      .rst_n            (rst_n),
      .i_mmio_write     (i_mmio_write),
      .i_mmio_read      (i_mmio_read),
      .i_mmio_addr      (i_mmio_addr),
      .i_mmio_wdata     (i_mmio_wdata),
      .i_mmio_32b       (i_mmio_32b),
      .o_csr_write      (csr_write),
      .o_csr_waddr      (csr_waddr),
      .o_csr_wdata      (csr_wdata),
      .o_csr_write_type (csr_write_type),
      .o_csr_read       (csr_read),
      .o_csr_raddr      (csr_raddr),
      .o_csr_read_32b   (csr_read_32b)
   );

   // Error stage
   pcie_err_collect u_err (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_pcie_linkup (i_pcie_linkup),
      .i_err_code    (i_err_code),
      .i_cpl_timeout (i_cpl_timeout),
      .o_linkup_sync (linkup_sync),
      .o_err_set     (err_set)
   );

   // Register file
   pcie_csr_regs u_regs (
      .clk              (clk),
      .rst_n            (rst_n),
      .i_csr_write      (csr_write),
      .i_csr_waddr      (csr_waddr),
      .i_csr_wdata      (csr_wdata),
      .i_csr_write_type (csr_write_type),
      .i_csr_read       (csr_read),
      .i_csr_raddr      (csr_raddr),
      .i_csr_read_32b   (csr_read_32b),
      .i_linkup         (linkup_sync),
      .i_err_set        (err_set),
      .i_ss_ack         (i_ss_ack),
      .i_ss_readdata    (i_ss_readdata),
      .o_rsp_valid      (o_rsp_valid),
      .o_rsp_data       (o_rsp_data),
      .o_ss_cmd         (o_ss_cmd),
      .o_ss_addr        (o_ss_addr),
      .o_ss_wdata       (o_ss_wdata),
      .o_pcie_error     (o_pcie_error)
   );

endmodule

// ==== test/tb_pcie_csr.sv ====
`timescale 1ns/100ps

module tb_pcie_csr;

   import pcie_csr_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 8;

   // Step kinds of the stimulus table
   typedef enum logic [2:0] {
      OP_READ,
      OP_WRITE,
      OP_LEVELS,
      OP_SS_IN,
      OP_CHK_ERR,
      OP_CHK_SS
   } e_op;

   // Levels err, cpl and link are held until the next OP_LEVELS row
   typedef struct packed {
      e_op         op;
      t_mmio_addr  addr;
      logic        is32;
      t_csr_data   wdata;
      logic [31:0] err;
      logic        cpl;
      logic        link;
      t_csr_data   exp_data;
   } t_row;

   //----------------------------------------------------------------------
   // DUT signals
   //----------------------------------------------------------------------
   logic        clk;
   logic        rst_n;
   logic        i_mmio_write;
   logic        i_mmio_read;
   t_mmio_addr  i_mmio_addr;
   t_csr_data   i_mmio_wdata;
   logic        i_mmio_32b;
   logic        i_pcie_linkup;
   logic [31:0] i_err_code;
   logic        i_cpl_timeout;
   logic        i_ss_ack;
   t_ss_data    i_ss_readdata;
   logic        o_rsp_valid;
   t_csr_data   o_rsp_data;
   t_ss_cmd     o_ss_cmd;
   t_ss_addr    o_ss_addr;
   t_ss_data    o_ss_wdata;
   logic [31:0] o_pcie_error;

   pcie_csr_top DUT (.*);

   // Table, counters and the expected register contents
   t_row        rows[$];
   int          n_errors;
   int          n_checks;
   logic        rows_built;
   logic [31:0] lcg_state;
   t_csr_data   dfh_exp;
   t_csr_data   scr_m;
   logic [32:0] err_m;
   logic [32:0] mask_m;
   t_ss_cmd     cmd_m;
   t_ss_addr    ssaddr_m;
   t_ss_data    sswd_m;
   t_ss_data    ssrd_m;
   logic        ack_m;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //----------------------------------------------------------------------
   // Helpers
   //----------------------------------------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic t_csr_data rand64();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi, lo};
   endfunction

   // Address at 49:32 with ack in bit 2 and command in 1:0
   function automatic t_csr_data ss_cmd_word();
      return (t_csr_data'(ssaddr_m) << 32) | (t_csr_data'(ack_m) << 2)
           | t_csr_data'(cmd_m);
   endfunction

   task automatic push_row(
      input e_op         op,
      input t_mmio_addr  addr,
      input logic        is32,
      input t_csr_data   wdata,
      input logic [31:0] err,
      input logic        cpl,
      input logic        link,
      input t_csr_data   exp_data
   );
      t_row r;
      r = '{op, addr, is32, wdata, err, cpl, link, exp_data};
      rows.push_back(r);
   endtask

   task automatic read_step(input t_mmio_addr addr, input logic is32, input t_csr_data exp_data);
      push_row(OP_READ, addr, is32, '0, '0, 1'b0, 1'b0, exp_data);
   endtask

   task automatic write_step(input t_mmio_addr addr, input logic is32, input t_csr_data data);
      push_row(OP_WRITE, addr, is32, data, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic compare_response(input t_mmio_addr addr, input t_csr_data exp_data);
      n_checks++;
      if (o_rsp_valid !== 1'b1) begin
         n_errors++;
         $display("Read at address %h got no response three edges after the request", addr);
      end else if (o_rsp_data !== exp_data) begin
         n_errors++;
         $display("** Error o_rsp_data at address %h: got %h, expected %h",
                  addr, o_rsp_data, exp_data);
      end
   endtask

   task automatic expect_no_response();
      n_checks++;
      if (o_rsp_valid !== 1'b0) begin
         n_errors++;
         $display("** Error o_rsp_valid: got %h, expected 0", o_rsp_valid);
      end
   endtask

   //----------------------------------------------------------------------
   // Stimulus table with expected values
   //----------------------------------------------------------------------
   task automatic build_table();
      t_csr_data rnd;
      // Header word from its fields
      dfh_exp = (t_csr_data'(FEAT_TYPE) << 60) | (t_csr_data'(END_OF_LIST) << 40)
              | (t_csr_data'(NEXT_DFH_OFFSET) << 16) | (t_csr_data'(FEAT_VER) << 12)
              | t_csr_data'(FEAT_ID);
      read_step(12'h000, 1'b0, dfh_exp);
      read_step(12'h004, 1'b1, {dfh_exp[63:32], 32'h0});
      read_step(12'h000, 1'b1, {32'h0, dfh_exp[31:0]});
      // Scratchpad full word then one lane at a time
      scr_m = rand64();
      write_step(12'h008, 1'b0, scr_m);
      read_step(12'h008, 1'b0, scr_m);
      rnd = rand64();
      write_step(12'h008, 1'b1, rnd);
      scr_m[31:0] = rnd[31:0];
      read_step(12'h008, 1'b0, scr_m);
      rnd = rand64();
      write_step(12'h00C, 1'b1, rnd);
      scr_m[63:32] = rnd[63:32];
      read_step(12'h008, 1'b0, scr_m);
      read_step(12'h008, 1'b1, {32'h0, scr_m[31:0]});
      read_step(12'h00C, 1'b1, {scr_m[63:32], 32'h0});
      // Sticky errors with the completion timeout in bit 32
      err_m  = 33'h1_8000_0013;
      mask_m = '0;
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h8000_0013, 1'b1, 1'b0, '0);
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0, 1'b0, 1'b0, '0);
      read_step(12'h020, 1'b0, {31'h0, err_m});
      push_row(OP_CHK_ERR, '0, 1'b0, '0, '0, 1'b0, 1'b0, {32'h0, err_m[31:0]});
      // Upper lane carries zero so bit 31 in the low half is ignored
      write_step(12'h024, 1'b1, 64'h0000_0000_8000_0000);
      read_step(12'h020, 1'b0, {31'h0, err_m});
      // Low lane clears bit 1 only and bit 32 survives the ones above
      write_step(12'h020, 1'b1, 64'hFFFF_FFFF_0000_0002);
      err_m[1] = 1'b0;
      read_step(12'h020, 1'b0, {31'h0, err_m});
      write_step(12'h020, 1'b0, 64'h0000_0001_0000_0001);
      err_m = err_m & ~33'h1_0000_0001;
      read_step(12'h020, 1'b0, {31'h0, err_m});
      push_row(OP_CHK_ERR, '0, 1'b0, '0, '0, 1'b0, 1'b0, {32'h0, err_m[31:0]});
      // Held source sets once and stays clear after W1C
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0000_0004, 1'b0, 1'b0, '0);
      err_m[2] = 1'b1;
      read_step(12'h020, 1'b0, {31'h0, err_m});
      write_step(12'h020, 1'b0, 64'h4);
      err_m[2] = 1'b0;
      read_step(12'h020, 1'b0, {31'h0, err_m});
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0, 1'b0, 1'b0, '0);
      // Mask bits 7:4 and the timeout with bits above 32 reading zero
      write_step(12'h018, 1'b0, 64'hFFFF_FFFF_0000_00F0);
      mask_m = 33'h1_0000_00F0;
      read_step(12'h018, 1'b0, {31'h0, mask_m});
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0000_0FF0, 1'b1, 1'b0, '0);
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0, 1'b0, 1'b0, '0);
      err_m = err_m | ({1'b1, 32'h0000_0FF0} & ~mask_m);
      read_step(12'h020, 1'b0, {31'h0, err_m});
      push_row(OP_CHK_ERR, '0, 1'b0, '0, '0, 1'b0, 1'b0, {32'h0, err_m[31:0]});
      // Sideband controls
      ack_m  = 1'b1;
      ssrd_m = lcg_next();
      push_row(OP_SS_IN, '0, 1'b0, {31'h0, ack_m, ssrd_m}, '0, 1'b0, 1'b0, '0);
      rnd = rand64();
      // Nonzero command so the write is visible after reset
      rnd[1:0] = 2'b10;
      write_step(12'h028, 1'b0, rnd);
      cmd_m    = rnd[1:0];
      ssaddr_m = rnd[49:32];
      read_step(12'h028, 1'b0, ss_cmd_word());
      rnd = rand64();
      write_step(12'h030, 1'b0, rnd);
      sswd_m = rnd[63:32];
      read_step(12'h030, 1'b0, {sswd_m, ssrd_m});
      push_row(OP_CHK_SS, '0, 1'b0, '0, '0, 1'b0, 1'b0, {12'h0, cmd_m, ssaddr_m, sswd_m});
      ack_m  = 1'b0;
      ssrd_m = lcg_next();
      push_row(OP_SS_IN, '0, 1'b0, {31'h0, ack_m, ssrd_m}, '0, 1'b0, 1'b0, '0);
      // Upper lane only so command bits keep their value
      rnd = rand64();
      write_step(12'h02C, 1'b1, rnd);
      ssaddr_m = rnd[49:32];
      read_step(12'h028, 1'b0, ss_cmd_word());
      // Low lane of SS data is read-only
      write_step(12'h030, 1'b1, rand64());
      read_step(12'h030, 1'b0, {sswd_m, ssrd_m});
      push_row(OP_CHK_SS, '0, 1'b0, '0, '0, 1'b0, 1'b0, {12'h0, cmd_m, ssaddr_m, sswd_m});
      // Link status
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0, 1'b0, 1'b1, '0);
      read_step(12'h010, 1'b0, 64'h1);
      push_row(OP_LEVELS, '0, 1'b0, '0, 32'h0, 1'b0, 1'b0, '0);
      read_step(12'h010, 1'b0, 64'h0);
      // Out of range where 0x108 would alias the scratchpad
      read_step(12'h038, 1'b0, '0);
      read_step(12'h100, 1'b0, '0);
      write_step(12'h108, 1'b0, rand64());
      read_step(12'h008, 1'b0, scr_m);
   endtask

   //----------------------------------------------------------------------
   // Row execution with each row starting on a rising edge
   //----------------------------------------------------------------------
   task automatic apply_row(input t_row r);
      @(posedge clk);
      case (r.op)
         OP_WRITE: begin
            i_mmio_write <= 1'b1;
            i_mmio_addr  <= r.addr;
            i_mmio_wdata <= r.wdata;
            i_mmio_32b   <= r.is32;
            @(posedge clk);
            i_mmio_write <= 1'b0;
         end
         OP_READ: begin
            i_mmio_read <= 1'b1;
            i_mmio_addr <= r.addr;
            i_mmio_32b  <= r.is32;
            @(posedge clk);
            i_mmio_read <= 1'b0;
            repeat (2) @(posedge clk);
            @(negedge clk);
            compare_response(r.addr, r.exp_data);
            // Valid lasts a single cycle
            @(negedge clk);
            expect_no_response();
         end
         OP_LEVELS: begin
            i_err_code    <= r.err;
            i_cpl_timeout <= r.cpl;
            i_pcie_linkup <= r.link;
            // Long enough for edge detect and sticky set or the link-up synchronizer
            repeat (4) @(posedge clk);
         end
         OP_SS_IN: begin
            i_ss_ack      <= r.wdata[32];
            i_ss_readdata <= r.wdata[31:0];
         end
         OP_CHK_ERR: begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            n_checks++;
            if (o_pcie_error !== r.exp_data[31:0]) begin
               n_errors++;
               $display("** Error o_pcie_error: got %h, expected %h",
                        o_pcie_error, r.exp_data[31:0]);
            end
         end
         OP_CHK_SS: begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            n_checks++;
            if ({o_ss_cmd, o_ss_addr, o_ss_wdata} !== r.exp_data[51:0]) begin
               n_errors++;
               $display("** Error o_ss_cmd/o_ss_addr/o_ss_wdata: got %h/%h/%h, expected %h/%h/%h",
                        o_ss_cmd, o_ss_addr, o_ss_wdata, r.exp_data[51:50],
                        r.exp_data[49:32], r.exp_data[31:0]);
            end
         end
         default: begin
         end
      endcase
   endtask

   //----------------------------------------------------------------------
   // Watchdog
   //----------------------------------------------------------------------
   initial begin
      int limit;
      wait (rows_built === 1'b1);
      // Burst counts as one more row
      limit = (rows.size() + 1) * 20 + RESET_CYCLES;
      repeat (limit) @(posedge clk);
      $display("Timeout: the test did not finish within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
   end

   //----------------------------------------------------------------------
   // Main sequence
   //----------------------------------------------------------------------
   initial begin
      n_errors      = 0;
      n_checks      = 0;
      lcg_state     = 32'd94193;
      rows_built    = 1'b0;
      rst_n         = 1'b0;
      i_mmio_write  = 1'b0;
      i_mmio_read   = 1'b0;
      i_mmio_addr   = '0;
      i_mmio_wdata  = '0;
      i_mmio_32b    = 1'b0;
      i_pcie_linkup = 1'b0;
      i_err_code    = '0;
      i_cpl_timeout = 1'b0;
      i_ss_ack      = 1'b0;
      i_ss_readdata = '0;
      build_table();
      rows_built = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      n_checks++;
      if (o_rsp_valid !== 1'b0 || o_ss_cmd !== '0 || o_pcie_error !== '0) begin
         n_errors++;
         $display("** Error after reset: o_rsp_valid %h, o_ss_cmd %h, o_pcie_error %h",
                  o_rsp_valid, o_ss_cmd, o_pcie_error);
      end
      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      // Back-to-back reads with responses in order
      @(posedge clk);
      i_mmio_read <= 1'b1;
      i_mmio_32b  <= 1'b0;
      i_mmio_addr <= 12'h000;
      @(posedge clk);
      i_mmio_addr <= 12'h008;
      @(posedge clk);
      i_mmio_addr <= 12'h020;
      @(posedge clk);
      i_mmio_read <= 1'b0;
      @(negedge clk);
      compare_response(12'h000, dfh_exp);
      @(negedge clk);
      compare_response(12'h008, scr_m);
      @(negedge clk);
      compare_response(12'h020, {31'h0, err_m});
      @(negedge clk);
      expect_no_response();
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== list.f ====
rtl/pcie_csr_pkg.sv
rtl/mmio_req_decode.sv
rtl/pcie_err_collect.sv
rtl/pcie_csr_regs.sv
rtl/pcie_csr_top.sv
test/tb_pcie_csr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the PCIe CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module tb_pcie_csr \
   -f list.f -o tb_pcie_csr_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_pcie_csr_sim > sim.log 2>&1 || echo "Simulator returned a failing status"
cat sim.log

grep -qxF '** PASS **' sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }
